//--- hdl/scaler_window_pkg.sv
/*
 * Scaler window package
 * Widths, reset defaults, host opcodes and structs shared along the window path
 */
`default_nettype none

package scaler_window_pkg;

	localparam int DIM_W  = 12;
	localparam int WORD_W = 16;

	typedef logic [DIM_W-1:0] dim_t;

	// Power-on video size, 1080p
	localparam dim_t DEF_WIDTH  = 12'd1920;
	localparam dim_t DEF_HEIGHT = 12'd1080;

	// Host opcodes still decoded
	typedef enum logic [7:0] {
		CMD_VIDEO_TIMING = 8'h20,
		CMD_VSET         = 8'h27,
		CMD_HSET         = 8'h37,
		CMD_ASPECT       = 8'h3A
	} host_cmd_e;

	typedef struct packed {
		logic              first;
		logic [WORD_W-1:0] data;
	} host_word_t;

	// Settings snapshot handed to the execute stage
	typedef struct packed {
		dim_t width;
		dim_t height;
		dim_t vset;
		dim_t hset;
		logic free_scale;
		dim_t arx;
		dim_t ary;
		logic direct_size;
	} scale_cfg_t;

	typedef struct packed {
		dim_t hmin;
		dim_t hmax;
		dim_t vmin;
		dim_t vmax;
	} window_t;

	typedef enum logic [2:0] {IDLE, PICK, MUL_W, MUL_H, CLAMP, CENTRE, HOLD} calc_state_e;

endpackage

`default_nettype wire

//--- hdl/umuldiv.sv
/*
 * Sequential unsigned multiply-divide
 * floor(mul1 * mul2 / div), saturated to all ones on overflow
 */
`default_nettype none

module umuldiv #(
	parameter int DIM_W = scaler_window_pkg::DIM_W
) (
	input  wire logic             i_clk_sys,
	input  wire logic             i_resetd,
	input  wire logic             i_start,
	input  wire logic [DIM_W-1:0] i_mul1,
	input  wire logic [DIM_W-1:0] i_mul2,
	input  wire logic [DIM_W-1:0] i_div,
	output logic                  o_busy,
	output logic [DIM_W-1:0]      o_result
);

	localparam int CNT_W = $clog2(DIM_W);

	logic [DIM_W-1:0] rem;
	logic [DIM_W-1:0] quo;
	logic [DIM_W-1:0] dvs;
	logic [DIM_W:0]   shifted;
	logic [DIM_W:0]   diff;
	logic [CNT_W-1:0] cnt;
	logic             chk;

	// One restoring step, remainder shifted left with the next dividend bit
	assign shifted  = {rem, quo[DIM_W-1]};
	assign diff     = shifted - {1'b0, dvs};
	assign o_result = quo;

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			o_busy <= 1'b0;
			chk    <= 1'b0;
			cnt    <= '0;
		end else if (i_start) begin
			o_busy <= 1'b1;
			chk    <= 1'b1;
			cnt    <= '0;
		end else if (o_busy) begin
			if (chk) begin
				chk <= 1'b0;
				// High half not below divisor means the quotient overflows
				if (rem >= dvs) begin
					o_busy <= 1'b0;
				end
			end else begin
				cnt <= cnt + 1'b1;
				if (cnt == CNT_W'(DIM_W - 1)) begin
					o_busy <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge i_clk_sys) begin
		if (i_start) begin
			{rem, quo} <= i_mul1 * i_mul2;
			dvs        <= i_div;
		end else if (o_busy && chk) begin
			if (rem >= dvs) begin
				quo <= '1;
			end
		end else if (o_busy) begin
			rem <= diff[DIM_W] ? shifted[DIM_W-1:0] : diff[DIM_W-1:0];
			quo <= {quo[DIM_W-2:0], ~diff[DIM_W]};
		end
	end

endmodule

`default_nettype wire

//--- hdl/host_cmd_decode.sv
/*
 * Host command decoder
 * Parses opcode and data words into the scaler settings and hands off a snapshot
 */
`default_nettype none

module host_cmd_decode (
	input  wire logic                          i_clk_sys,
	input  wire logic                          i_resetd,
	input  wire scaler_window_pkg::host_word_t i_host_word,
	input  wire logic                          i_host_valid,
	output logic                               o_host_ready,
	output scaler_window_pkg::scale_cfg_t      o_cfg,
	output logic                               o_cfg_valid,
	input  wire logic                          i_cfg_ready
);

	scaler_window_pkg::scale_cfg_t cfg_q;
	scaler_window_pkg::host_cmd_e  cmd;
	scaler_window_pkg::dim_t       din;
	logic                          cmd_act;
	logic [2:0]                    word_cnt;
	logic                          cfg_pend;
	logic                          host_xfer;
	logic                          last_word;

	// Host waits only while a snapshot sits unaccepted
	assign o_host_ready = ~(cfg_pend & ~i_cfg_ready);
	assign host_xfer    = i_host_valid & o_host_ready;
	assign din          = i_host_word.data[scaler_window_pkg::DIM_W-1:0];

	assign o_cfg       = cfg_q;
	assign o_cfg_valid = cfg_pend;

	always_comb begin
		case (cmd)
			scaler_window_pkg::CMD_VIDEO_TIMING: last_word = (word_cnt == 3'd7);
			scaler_window_pkg::CMD_ASPECT:       last_word = (word_cnt == 3'd1);
			default:                             last_word = 1'b1;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Word parser

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			cmd_act  <= 1'b0;
			cmd      <= scaler_window_pkg::CMD_VSET;
			word_cnt <= '0;
			cfg_pend <= 1'b0;
			cfg_q    <= '{width:  scaler_window_pkg::DEF_WIDTH,
			              height: scaler_window_pkg::DEF_HEIGHT,
			              default: '0};
		end else begin
			if (cfg_pend && i_cfg_ready) begin
				cfg_pend <= 1'b0;
			end
			if (host_xfer) begin
				if (i_host_word.first) begin
					word_cnt <= '0;
					case (i_host_word.data[7:0])
						scaler_window_pkg::CMD_VIDEO_TIMING,
						scaler_window_pkg::CMD_VSET,
						scaler_window_pkg::CMD_HSET,
						scaler_window_pkg::CMD_ASPECT: begin
							cmd_act <= 1'b1;
							cmd     <= scaler_window_pkg::host_cmd_e'(i_host_word.data[7:0]);
						end
						default: begin
							cmd_act <= 1'b0;
						end
					endcase
				end else if (cmd_act) begin
					word_cnt <= word_cnt + 3'd1;
					case (cmd)
						scaler_window_pkg::CMD_VIDEO_TIMING: begin
							// Only active size kept, porches and syncs dropped
							if (word_cnt == 3'd0) begin
								cfg_q.width <= din;
							end
							if (word_cnt == 3'd4) begin
								cfg_q.height <= din;
							end
						end
						scaler_window_pkg::CMD_VSET: begin
							cfg_q.vset <= din;
						end
						scaler_window_pkg::CMD_HSET: begin
							cfg_q.hset       <= din;
							cfg_q.free_scale <= i_host_word.data[15];
						end
						scaler_window_pkg::CMD_ASPECT: begin
							if (word_cnt == 3'd0) begin
								cfg_q.arx         <= din;
								cfg_q.direct_size <= i_host_word.data[12];
							end else begin
								cfg_q.ary         <= din;
								cfg_q.direct_size <= cfg_q.direct_size | i_host_word.data[12];
							end
						end
						default: begin
							cmd_act <= 1'b0;
						end
					endcase
					// Surplus words fall through as stray data
					if (last_word) begin
						cmd_act  <= 1'b0;
						cfg_pend <= 1'b1;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/window_calc.sv
/*
 * Window execute stage
 * Picks the video size, aspect-corrects it, then clamps and centres the window
 */
`default_nettype none

module window_calc (
	input  wire logic                          i_clk_sys,
	input  wire logic                          i_resetd,
	input  wire scaler_window_pkg::scale_cfg_t i_cfg,
	input  wire logic                          i_cfg_valid,
	output logic                               o_cfg_ready,
	output scaler_window_pkg::window_t         o_win,
	output logic                               o_win_valid,
	input  wire logic                          i_win_ready
);

	scaler_window_pkg::calc_state_e state;
	scaler_window_pkg::scale_cfg_t  cfg_r;
	scaler_window_pkg::dim_t        tgt_w;
	scaler_window_pkg::dim_t        tgt_h;
	scaler_window_pkg::dim_t        wcalc;
	scaler_window_pkg::dim_t        hcalc;
	scaler_window_pkg::dim_t        videow;
	scaler_window_pkg::dim_t        videoh;
	scaler_window_pkg::dim_t        hoff;
	scaler_window_pkg::dim_t        voff;
	scaler_window_pkg::dim_t        hmin;
	scaler_window_pkg::dim_t        hmax;
	scaler_window_pkg::dim_t        vmin;
	scaler_window_pkg::dim_t        vmax;
	scaler_window_pkg::dim_t        md_mul1;
	scaler_window_pkg::dim_t        md_mul2;
	scaler_window_pkg::dim_t        md_div;
	scaler_window_pkg::dim_t        md_res;
	logic                           md_start;
	logic                           md_busy;
	logic                           md_idle;
	logic                           md_sel_h;
	logic                           use_target;
	logic                           use_direct;

	assign o_cfg_ready = (state == scaler_window_pkg::IDLE);

	// Overrides only shrink the output size
	assign tgt_h = (cfg_r.vset != '0 && cfg_r.vset < cfg_r.height) ? cfg_r.vset : cfg_r.height;
	assign tgt_w = (cfg_r.hset != '0 && cfg_r.hset < cfg_r.width) ? cfg_r.hset : cfg_r.width;

	assign use_target = cfg_r.free_scale || cfg_r.arx == '0 || cfg_r.ary == '0;
	assign use_direct = cfg_r.direct_size;

	////////////////////////////////////////////////////////////
	// Aspect multiply-divide, width pass then height pass

	assign md_sel_h = (state == scaler_window_pkg::MUL_H);
	assign md_mul1  = md_sel_h ? tgt_w : tgt_h;
	assign md_mul2  = md_sel_h ? cfg_r.ary : cfg_r.arx;
	assign md_div   = md_sel_h ? cfg_r.arx : cfg_r.ary;
	assign md_idle  = ~md_start & ~md_busy;

	umuldiv #(
		.DIM_W(scaler_window_pkg::DIM_W)
	) i_umuldiv (
		.i_clk_sys(i_clk_sys),
		.i_resetd (i_resetd),
		.i_start  (md_start),
		.i_mul1   (md_mul1),
		.i_mul2   (md_mul2),
		.i_div    (md_div),
		.o_busy   (md_busy),
		.o_result (md_res)
	);

	// Centring, wraps at 12 bits
	assign hoff = cfg_r.width - videow;
	assign voff = cfg_r.height - videoh;
	assign hmin = hoff >> 1;
	assign vmin = voff >> 1;
	assign hmax = hmin + videow - 12'd1;
	assign vmax = vmin + videoh - 12'd1;

	////////////////////////////////////////////////////////////
	// FSM

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			state       <= scaler_window_pkg::IDLE;
			md_start    <= 1'b0;
			o_win_valid <= 1'b0;
		end else begin
			md_start <= 1'b0;
			case (state)
				scaler_window_pkg::IDLE: begin
					if (i_cfg_valid) begin
						state <= scaler_window_pkg::PICK;
					end
				end
				scaler_window_pkg::PICK: begin
					if (use_target || use_direct) begin
						state <= scaler_window_pkg::CLAMP;
					end else begin
						md_start <= 1'b1;
						state    <= scaler_window_pkg::MUL_W;
					end
				end
				scaler_window_pkg::MUL_W: begin
					if (md_idle) begin
						md_start <= 1'b1;
						state    <= scaler_window_pkg::MUL_H;
					end
				end
				scaler_window_pkg::MUL_H: begin
					if (md_idle) begin
						state <= scaler_window_pkg::CLAMP;
					end
				end
				scaler_window_pkg::CLAMP: begin
					state <= scaler_window_pkg::CENTRE;
				end
				scaler_window_pkg::CENTRE: begin
					o_win_valid <= 1'b1;
					state       <= scaler_window_pkg::HOLD;
				end
				scaler_window_pkg::HOLD: begin
					if (i_win_ready) begin
						o_win_valid <= 1'b0;
						state       <= scaler_window_pkg::IDLE;
					end
				end
				default: begin
					state <= scaler_window_pkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge i_clk_sys) begin
		case (state)
			scaler_window_pkg::IDLE: begin
				if (i_cfg_valid) begin
					cfg_r <= i_cfg;
				end
			end
			scaler_window_pkg::PICK: begin
				wcalc <= use_target ? tgt_w : cfg_r.arx;
				hcalc <= use_target ? tgt_h : cfg_r.ary;
			end
			scaler_window_pkg::MUL_W: begin
				if (md_idle) begin
					wcalc <= md_res;
				end
			end
			scaler_window_pkg::MUL_H: begin
				if (md_idle) begin
					hcalc <= md_res;
				end
			end
			scaler_window_pkg::CLAMP: begin
				videow <= (wcalc > tgt_w) ? tgt_w : wcalc;
				videoh <= (hcalc > tgt_h) ? tgt_h : hcalc;
			end
			scaler_window_pkg::CENTRE: begin
				o_win <= '{hmin: hmin, hmax: hmax, vmin: vmin, vmax: vmax};
			end
			default: begin
			end
		endcase
	end

endmodule

`default_nettype wire

//--- hdl/window_out.sv
/*
 * Window result queue
 * Two-entry FIFO between the execute stage and the output
 */
`default_nettype none

module window_out (
	input  wire logic                       i_clk_sys,
	input  wire logic                       i_resetd,
	input  wire scaler_window_pkg::window_t i_win,
	input  wire logic                       i_win_valid,
	output logic                            o_win_ready,
	output scaler_window_pkg::window_t      o_win,
	output logic                            o_win_valid,
	input  wire logic                       i_win_ready
);

	scaler_window_pkg::window_t mem [2];
	logic                       wr_ptr;
	logic                       rd_ptr;
	logic [1:0]                 count;
	logic                       push;
	logic                       pop;

	assign o_win_ready = (count != 2'd2);
	assign o_win_valid = (count != 2'd0);
	assign o_win       = mem[rd_ptr];

	assign push = i_win_valid & o_win_ready;
	assign pop  = o_win_valid & i_win_ready;

	always_ff @(posedge i_clk_sys) begin
		if (push) begin
			mem[wr_ptr] <= i_win;
		end
	end

	always_ff @(posedge i_clk_sys) begin
		if (i_resetd) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count  <= 2'd0;
		end else begin
			wr_ptr <= wr_ptr ^ push;
			rd_ptr <= rd_ptr ^ pop;
			case ({push, pop})
				2'b10:   count <= count + 2'd1;
				2'b01:   count <= count - 2'd1;
				default: count <= count;
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/scaler_window_top.sv
/*
 * Scaler window top
 * Host command decode, window execute and result queue in a chain
 */
`default_nettype none

module scaler_window_top (
	input  wire logic                          i_clk_sys,
	input  wire logic                          i_resetd,
	input  wire scaler_window_pkg::host_word_t i_host_word,
	input  wire logic                          i_host_valid,
	output logic                               o_host_ready,
	output scaler_window_pkg::window_t         o_win,
	output logic                               o_win_valid,
	input  wire logic                          i_win_ready
);

	scaler_window_pkg::scale_cfg_t cfg;
	logic                          cfg_valid;
	logic                          cfg_ready;
	scaler_window_pkg::window_t    win;
	logic                          win_valid;
	logic                          win_ready;

	host_cmd_decode i_host_cmd_decode (
		.i_clk_sys   (i_clk_sys),
		.i_resetd    (i_resetd),
		.i_host_word (i_host_word),
		.i_host_valid(i_host_valid),
		.o_host_ready(o_host_ready),
		.o_cfg       (cfg),
		.o_cfg_valid (cfg_valid),
		.i_cfg_ready (cfg_ready)
	);

	window_calc i_window_calc (
		.i_clk_sys  (i_clk_sys),
		.i_resetd   (i_resetd),
		.i_cfg      (cfg),
		.i_cfg_valid(cfg_valid),
		.o_cfg_ready(cfg_ready),
		.o_win      (win),
		.o_win_valid(win_valid),
		.i_win_ready(win_ready)
	);

	window_out i_window_out (
		.i_clk_sys  (i_clk_sys),
		.i_resetd   (i_resetd),
		.i_win      (win),
		.i_win_valid(win_valid),
		.o_win_ready(win_ready),
		.o_win      (o_win),
		.o_win_valid(o_win_valid),
		.i_win_ready(i_win_ready)
	);

endmodule

`default_nettype wire

//--- bench/tb_window_model.svh
/*
 * Scaler window reference model
 * Settings mirror, window rules, LFSR step and the value check
 */
`ifndef TB_WINDOW_MODEL_SVH
`define TB_WINDOW_MODEL_SVH

// Settings mirror
scaler_window_pkg::dim_t m_width;
scaler_window_pkg::dim_t m_height;
scaler_window_pkg::dim_t m_vset;
scaler_window_pkg::dim_t m_hset;
scaler_window_pkg::dim_t m_arx;
scaler_window_pkg::dim_t m_ary;
logic                    m_free;
logic                    m_direct;
logic                    m_active;
logic [7:0]              m_op;
int                      m_count;

// Galois form, taps 32 22 2 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
endfunction

task automatic check_value(input string what, input logic [31:0] got,
		input logic [31:0] exp);
	if (got !== exp) begin
		$display("[ERROR] %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
		$display("TEST RESULT: FAIL");
		$fatal(1, "value mismatch");
	end
endtask

function automatic void model_reset();
	m_width  = scaler_window_pkg::DEF_WIDTH;
	m_height = scaler_window_pkg::DEF_HEIGHT;
	m_vset   = '0;
	m_hset   = '0;
	m_arx    = '0;
	m_ary    = '0;
	m_free   = 1'b0;
	m_direct = 1'b0;
	m_active = 1'b0;
	m_op     = '0;
	m_count  = 0;
endfunction

// Exact floor of a*b/d, all ones when it does not fit
function automatic scaler_window_pkg::dim_t muldiv(input scaler_window_pkg::dim_t a,
		input scaler_window_pkg::dim_t b, input scaler_window_pkg::dim_t d);
	logic [23:0] q;
	q = ({12'd0, a} * {12'd0, b}) / {12'd0, d};
	return (q > 24'd4095) ? 12'hfff : q[11:0];
endfunction

function automatic scaler_window_pkg::window_t model_window();
	scaler_window_pkg::dim_t   tw;
	scaler_window_pkg::dim_t   th;
	scaler_window_pkg::dim_t   vw;
	scaler_window_pkg::dim_t   vh;
	scaler_window_pkg::dim_t   hoff;
	scaler_window_pkg::dim_t   voff;
	scaler_window_pkg::window_t w;
	th = (m_vset != 0 && m_vset < m_height) ? m_vset : m_height;
	tw = (m_hset != 0 && m_hset < m_width) ? m_hset : m_width;
	if (m_free || m_arx == 0 || m_ary == 0) begin
		vw = tw;
		vh = th;
	end else if (m_direct) begin
		vw = m_arx;
		vh = m_ary;
	end else begin
		vw = muldiv(th, m_arx, m_ary);
		vh = muldiv(tw, m_ary, m_arx);
	end
	vw     = (vw > tw) ? tw : vw;
	vh     = (vh > th) ? th : vh;
	hoff   = m_width - vw;
	voff   = m_height - vh;
	w.hmin = hoff >> 1;
	w.vmin = voff >> 1;
	w.hmax = w.hmin + vw - 12'd1;
	w.vmax = w.vmin + vh - 12'd1;
	return w;
endfunction

// Applies one host word, returns 1 when a command completes
function automatic bit model_word(input scaler_window_pkg::host_word_t w);
	bit                      last;
	scaler_window_pkg::dim_t v;
	last = 1'b0;
	v    = w.data[11:0];
	if (w.first) begin
		m_count  = 0;
		m_op     = w.data[7:0];
		m_active = (m_op == scaler_window_pkg::CMD_VIDEO_TIMING) ||
			(m_op == scaler_window_pkg::CMD_VSET) ||
			(m_op == scaler_window_pkg::CMD_HSET) ||
			(m_op == scaler_window_pkg::CMD_ASPECT);
		return 1'b0;
	end
	if (!m_active) begin
		return 1'b0;
	end
	case (m_op)
		scaler_window_pkg::CMD_VIDEO_TIMING: begin
			if (m_count == 0) begin
				m_width = v;
			end
			if (m_count == 4) begin
				m_height = v;
			end
			last = (m_count == 7);
		end
		scaler_window_pkg::CMD_VSET: begin
			m_vset = v;
			last   = 1'b1;
		end
		scaler_window_pkg::CMD_HSET: begin
			m_hset = v;
			m_free = w.data[15];
			last   = 1'b1;
		end
		default: begin
			if (m_count == 0) begin
				m_arx    = v;
				m_direct = w.data[12];
			end else begin
				m_ary    = v;
				m_direct = m_direct | w.data[12];
				last     = 1'b1;
			end
		end
	endcase
	m_count++;
	if (last) begin
		m_active = 1'b0;
	end
	return last;
endfunction

`endif

//--- bench/tb_scaler_window.sv
/*
 * Scaler window testbench
 * Random host commands checked against a window model under back-pressure
 */
`default_nettype none

module tb_scaler_window;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int          CLK_NS   = 100;
	localparam int          DRIVE_NS = 10;
	localparam logic [31:0] SEED     = 32'h5a5194f5;

	logic                          clk_sys;
	logic                          resetd;
	scaler_window_pkg::host_word_t host_word;
	logic                          host_valid;
	logic                          host_ready;
	scaler_window_pkg::window_t    win;
	logic                          win_valid;
	logic                          win_ready;

	scaler_window_pkg::host_word_t word_q[$];
	scaler_window_pkg::window_t    exp_q[$];
	scaler_window_pkg::window_t    exp_win;
	logic [31:0]                   host_lfsr;
	logic [31:0]                   ready_lfsr;
	int                            word_total = 0;
	int                            expected_count = 0;
	int                            received_count = 0;

	`include "tb_window_model.svh"

	scaler_window_top i_scaler_window_top (
		.i_clk_sys   (clk_sys),
		.i_resetd    (resetd),
		.i_host_word (host_word),
		.i_host_valid(host_valid),
		.o_host_ready(host_ready),
		.o_win       (win),
		.o_win_valid (win_valid),
		.i_win_ready (win_ready)
	);

	initial begin
		clk_sys = 1'b0;
		forever begin
			#(CLK_NS / 2) clk_sys = ~clk_sys;
		end
	end

	function automatic logic [31:0] host_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v         = {v[30:0], host_lfsr[0]};
			host_lfsr = lfsr_step(host_lfsr);
		end
		return v;
	endfunction

	function automatic logic [31:0] ready_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v          = {v[30:0], ready_lfsr[0]};
			ready_lfsr = lfsr_step(ready_lfsr);
		end
		return v;
	endfunction

	////////////////////////////////////////////////////////////
	// Command word builders

	task automatic push_word(input logic first, input logic [15:0] data);
		scaler_window_pkg::host_word_t w;
		w.first = first;
		w.data  = data;
		word_q.push_back(w);
	endtask

	// Upper byte of the opcode word is noise
	task automatic opcode_word(input logic [7:0] op);
		logic [15:0] d;
		d      = host_bits(16);
		d[7:0] = op;
		push_word(1'b1, d);
	endtask

	task automatic timing_cmd(input logic [11:0] w, input logic [11:0] h);
		logic [15:0] d;
		opcode_word(scaler_window_pkg::CMD_VIDEO_TIMING);
		for (int i = 0; i < 8; i++) begin
			d = host_bits(16);
			if (i == 0) begin
				d[11:0] = w;
			end else if (i == 4) begin
				d[11:0] = h;
			end
			push_word(1'b0, d);
		end
	endtask

	task automatic vset_cmd(input logic [11:0] v);
		logic [15:0] d;
		opcode_word(scaler_window_pkg::CMD_VSET);
		d       = host_bits(16);
		d[11:0] = v;
		push_word(1'b0, d);
	endtask

	task automatic hset_cmd(input logic [11:0] h, input logic fs);
		logic [15:0] d;
		opcode_word(scaler_window_pkg::CMD_HSET);
		d       = host_bits(16);
		d[11:0] = h;
		d[15]   = fs;
		push_word(1'b0, d);
	endtask

	task automatic aspect_cmd(input logic [11:0] x, input logic [11:0] y, input logic direct);
		logic [15:0] d0;
		logic [15:0] d1;
		logic [1:0]  sel;
		opcode_word(scaler_window_pkg::CMD_ASPECT);
		d0       = host_bits(16);
		d1       = host_bits(16);
		sel      = host_bits(2);
		d0[11:0] = x;
		d1[11:0] = y;
		// Direct flag may come from either word
		d0[12]   = direct & sel[0];
		d1[12]   = direct & (~sel[0] | sel[1]);
		push_word(1'b0, d0);
		push_word(1'b0, d1);
	endtask

	function automatic logic [11:0] aspect_value();
		logic [2:0] kind;
		kind = host_bits(3);
		if (kind == 3'd0) begin
			return '0;
		end
		if (kind < 3'd5) begin
			return 12'd1 + host_bits(4);
		end
		return host_bits(12);
	endfunction

	function automatic logic [11:0] override_value();
		return host_bits(1) ? 12'd0 : host_bits(12);
	endfunction

	task automatic random_cmd();
		case (host_bits(2))
			0: timing_cmd(12'd256 + host_bits(11), 12'd128 + host_bits(10));
			1: vset_cmd(override_value());
			2: hset_cmd(override_value(), host_bits(1));
			default: aspect_cmd(aspect_value(), aspect_value(), host_bits(1));
		endcase
	endtask

	// Unknown opcode, aborted and surplus words, then a real command
	task automatic noise_words();
		logic [7:0] op;
		op = host_bits(8);
		if (op == 8'h20 || op == 8'h27 || op == 8'h37 || op == 8'h3A) begin
			op = op ^ 8'h01;
		end
		opcode_word(op);
		repeat (1 + host_bits(2)) push_word(1'b0, host_bits(16));
		vset_cmd(override_value());
		repeat (1 + host_bits(2)) push_word(1'b0, host_bits(16));
		opcode_word(scaler_window_pkg::CMD_ASPECT);
		push_word(1'b0, host_bits(16));
		random_cmd();
	endtask

	////////////////////////////////////////////////////////////
	// Host driver and window monitor

	task automatic drive_word(input scaler_window_pkg::host_word_t w);
		bit sent;
		sent       = 1'b0;
		host_word  = w;
		host_valid = 1'b1;
		while (!sent) begin
			@(negedge clk_sys);
			sent = host_ready;
			@(posedge clk_sys);
			#(DRIVE_NS);
		end
		host_valid = 1'b0;
		if (model_word(w)) begin
			exp_q.push_back(model_window());
			expected_count++;
		end
	endtask

	initial begin
		ready_lfsr = SEED;
		win_ready  = 1'b0;
		forever begin
			@(posedge clk_sys);
			#(DRIVE_NS);
			win_ready = (ready_bits(3) > 32'd2);
		end
	end

	initial begin
		forever begin
			@(negedge clk_sys);
			if (!resetd && win_valid && win_ready) begin
				if (exp_q.size() == 0) begin
					$display("[ERROR] %0t ns: a window came out with none expected", $time);
					$display("TEST RESULT: FAIL");
					$fatal(1, "extra window");
				end else begin
					exp_win = exp_q.pop_front();
					// First window comes from a lone VSET of 0 on the reset settings
					if (received_count == 0) begin
						check_value("default hmin", win.hmin, 0);
						check_value("default hmax", win.hmax, 1919);
						check_value("default vmin", win.vmin, 0);
						check_value("default vmax", win.vmax, 1079);
					end
					check_value($sformatf("window %0d hmin", received_count), win.hmin, exp_win.hmin);
					check_value($sformatf("window %0d hmax", received_count), win.hmax, exp_win.hmax);
					check_value($sformatf("window %0d vmin", received_count), win.vmin, exp_win.vmin);
					check_value($sformatf("window %0d vmax", received_count), win.vmax, exp_win.vmax);
					received_count++;
				end
			end
		end
	end

	initial begin
		wait (word_total != 0);
		#(word_total * 60 * CLK_NS);
		$display("Timeout: the run did not finish within %0d clock cycles", word_total * 60);
		$display("TEST RESULT: FAIL");
		$fatal(1, "watchdog expired");
	end

	////////////////////////////////////////////////////////////
	// Main sequence

	initial begin
		resetd     = 1'b1;
		host_valid = 1'b0;
		host_word  = '0;
		host_lfsr  = SEED;
		model_reset();

		vset_cmd(12'd0);
		repeat (12) begin
			timing_cmd(12'd256 + host_bits(11), 12'd128 + host_bits(10));
			vset_cmd(override_value());
			hset_cmd(override_value(), 1'b1);
		end
		hset_cmd(12'd0, 1'b0);
		vset_cmd(12'd0);
		timing_cmd(12'd1920, 12'd1080);
		// Width pass overflows and saturates to the target width
		aspect_cmd(12'd2048, 12'd1, 1'b0);
		repeat (30) begin
			if (host_bits(2) == 0) begin
				timing_cmd(12'd256 + host_bits(11), 12'd128 + host_bits(10));
			end
			aspect_cmd(aspect_value(), aspect_value(), 1'b0);
		end
		repeat (15) aspect_cmd(host_bits(12), host_bits(12), 1'b1);
		repeat (20) noise_words();
		repeat (40) random_cmd();
		word_total = word_q.size();

		repeat (2) @(posedge clk_sys);
		#(DRIVE_NS);
		resetd = 1'b0;
		// Nothing may come out before any word
		repeat (10) begin
			@(negedge clk_sys);
			check_value("o_win_valid while idle", win_valid, 0);
			check_value("o_host_ready while idle", host_ready, 1);
		end
		@(posedge clk_sys);
		#(DRIVE_NS);

		foreach (word_q[i]) begin
			drive_word(word_q[i]);
			repeat (host_bits(1) ? 0 : host_bits(2)) begin
				@(posedge clk_sys);
				#(DRIVE_NS);
			end
		end

		while (exp_q.size() != 0) begin
			@(posedge clk_sys);
		end
		repeat (60) @(posedge clk_sys);
		if (received_count == expected_count) begin
			$display("%0d windows checked", received_count);
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("[ERROR] %0t ns: received %0d windows, expected %0d",
				$time, received_count, expected_count);
			$display("TEST RESULT: FAIL");
			$fatal(1, "window count mismatch");
		end
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+bench
hdl/scaler_window_pkg.sv
hdl/umuldiv.sv
hdl/host_cmd_decode.sv
hdl/window_calc.sv
hdl/window_out.sv
hdl/scaler_window_top.sv
bench/tb_scaler_window.sv

//--- Bender.yml
package:
  name: scaler_window

sources:
  # Design sources
  - target: any(rtl, test)
    files:
      - hdl/scaler_window_pkg.sv
      - hdl/umuldiv.sv
      - hdl/host_cmd_decode.sv
      - hdl/window_calc.sv
      - hdl/window_out.sv
      - hdl/scaler_window_top.sv

  # Testbench
  - target: test
    include_dirs:
      - bench
    files:
      - bench/tb_scaler_window.sv
